/* src/fft_cfg_pkg.sv */
/*
 * Sizes and scalar types of the 32-point FFT output reorder unit.
 * The index rules in the reorder logic are written for a 5-bit index.
 * Changing FFT_LEN alone does not give a working unit.
 */
package fft_cfg_pkg;

    // --------------------
    // frame geometry
    // --------------------

    // complex samples in one frame
    localparam int unsigned FFT_LEN      = 32;

    // bits needed to address one sample of a frame
    localparam int unsigned LOG2_FFT_LEN = 5;

    // --------------------
    // field widths
    // --------------------

    // one real or one imaginary part
    localparam int unsigned DATA_WID = 16;

    // stage number carried with each frame
    localparam int unsigned STG_WID  = 3;

    // --------------------
    // scalar types
    // --------------------

    // two's complement, same format for re and im
    typedef logic signed [DATA_WID-1:0] sample_t;

    // position of a sample inside a frame
    typedef logic [LOG2_FFT_LEN-1:0] index_t;

    // stage 0 is bit reversal, 1 to 4 rotate, 5 to 7 pass through
    typedef logic [STG_WID-1:0] stage_t;

endpackage

/* src/fft_frame_pkg.sv */
/*
 * Frame level types of the reorder unit.
 * Sample 0 sits in the lowest bits of the samples field.
 * The stage field is above all samples.
 */
package fft_frame_pkg;

    // --------------------
    // data structs
    // --------------------

    // re in the upper half, im in the lower half
    typedef struct packed {
        fft_cfg_pkg::sample_t re;
        fft_cfg_pkg::sample_t im;
    } cplx_t;

    // one full frame, 3 + 1024 bits
    typedef struct packed {
        fft_cfg_pkg::stage_t                stage;
        cplx_t [fft_cfg_pkg::FFT_LEN-1:0]   samples;
    } frame_t;

    // --------------------
    // reorder control
    // --------------------

    // entry i names the input sample that goes to output position i
    typedef fft_cfg_pkg::index_t [fft_cfg_pkg::FFT_LEN-1:0] idx_list_t;

    // ORD_ROTn rotates the low n index bits right by one
    typedef enum logic [2:0] {
        ORD_BITREV = 3'd0,
        ORD_ROT2   = 3'd1,
        ORD_ROT3   = 3'd2,
        ORD_ROT4   = 3'd3,
        ORD_ROT5   = 3'd4,
        ORD_PASS   = 3'd5
    } ord_mode_e;

endpackage

/* src/fft_ord_capture.sv */
/*
 * First pipeline slot of the reorder unit.
 * in_frame_i must stay steady while in_valid_i waits for in_ready_o.
 * in_ready_o depends on cap_ready_i in the same cycle.
 */
`timescale 1ns/1ps

module fft_ord_capture (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            in_valid_i,
    input  fft_frame_pkg::frame_t                           in_frame_i,
    output logic                                            in_ready_o,
    output logic                                            load_o,
    output logic                                            cap_valid_o,
    output fft_frame_pkg::cplx_t [fft_cfg_pkg::FFT_LEN-1:0] cap_samples_o,
    input  logic                                            cap_ready_i
);

    // --------------------
    // handshake
    // --------------------

    // slot is empty, or its frame moves to the crossbar this cycle
    assign in_ready_o = !cap_valid_o || cap_ready_i;

    // accept pulse, also loads the index table
    assign load_o = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cap_valid_o <= 1'b0;
        end else if (load_o) begin
            cap_valid_o <= 1'b1;
        end else if (cap_ready_i) begin
            // frame handed on and nothing new arrived
            cap_valid_o <= 1'b0;
        end
    end

    // --------------------
    // sample register
    // --------------------

    // stage is kept by the index table, only samples are held here
    always_ff @(posedge clk) begin
        if (load_o) begin
            cap_samples_o <= in_frame_i.samples;
        end
    end

endmodule

/* src/fft_ord_index_table.sv */
/*
 * Builds the source index list for a frame from its stage number.
 * The rules assume a 5-bit sample index.
 * List and stage are registered on load_i, in step with the capture slot.
 */
`timescale 1ns/1ps

module fft_ord_index_table (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      load_i,
    input  fft_cfg_pkg::stage_t       stage_i,
    output fft_frame_pkg::idx_list_t  idx_list_o,
    output fft_cfg_pkg::stage_t       stage_o
);

    fft_frame_pkg::ord_mode_e  mode;
    fft_frame_pkg::idx_list_t  idx_list_d;

    // --------------------
    // index rules
    // --------------------

    // mirror all 5 index bits
    function automatic fft_cfg_pkg::index_t bit_rev(input fft_cfg_pkg::index_t idx);
        fft_cfg_pkg::index_t r;
        for (int unsigned b = 0; b < fft_cfg_pkg::LOG2_FFT_LEN; b++) begin
            r[b] = idx[fft_cfg_pkg::LOG2_FFT_LEN-1-b];
        end
        return r;
    endfunction

    // rotate the low n bits right by one, upper bits stay put
    function automatic fft_cfg_pkg::index_t rot_low(input fft_cfg_pkg::index_t idx,
                                                    input int unsigned n);
        fft_cfg_pkg::index_t low_mask;
        fft_cfg_pkg::index_t rot;
        low_mask   = fft_cfg_pkg::index_t'((1 << n) - 1);
        rot        = (idx & low_mask) >> 1;
        rot[n-1]   = idx[0];
        return (idx & ~low_mask) | rot;
    endfunction

    // --------------------
    // stage decode
    // --------------------

    // stage s in 1..4 rotates s+1 bits
    always_comb begin
        case (stage_i)
            3'd0:    mode = fft_frame_pkg::ORD_BITREV;
            3'd1:    mode = fft_frame_pkg::ORD_ROT2;
            3'd2:    mode = fft_frame_pkg::ORD_ROT3;
            3'd3:    mode = fft_frame_pkg::ORD_ROT4;
            3'd4:    mode = fft_frame_pkg::ORD_ROT5;
            default: mode = fft_frame_pkg::ORD_PASS;
        endcase
    end

    always_comb begin
        for (int i = 0; i < fft_cfg_pkg::FFT_LEN; i++) begin
            case (mode)
                fft_frame_pkg::ORD_BITREV:
                    idx_list_d[i] = bit_rev(fft_cfg_pkg::index_t'(i));
                fft_frame_pkg::ORD_ROT2:
                    idx_list_d[i] = rot_low(fft_cfg_pkg::index_t'(i), 2);
                fft_frame_pkg::ORD_ROT3:
                    idx_list_d[i] = rot_low(fft_cfg_pkg::index_t'(i), 3);
                fft_frame_pkg::ORD_ROT4:
                    idx_list_d[i] = rot_low(fft_cfg_pkg::index_t'(i), 4);
                fft_frame_pkg::ORD_ROT5:
                    idx_list_d[i] = rot_low(fft_cfg_pkg::index_t'(i), 5);
                default:
                    idx_list_d[i] = fft_cfg_pkg::index_t'(i);
            endcase
        end
    end

    // --------------------
    // list register
    // --------------------

    // out of reset the table describes a pass-through frame at stage 7
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stage_o <= '1;
            for (int i = 0; i < fft_cfg_pkg::FFT_LEN; i++) begin
                idx_list_o[i] <= fft_cfg_pkg::index_t'(i);
            end
        end else if (load_i) begin
            stage_o    <= stage_i;
            idx_list_o <= idx_list_d;
        end
    end

endmodule

/* src/fft_ord_crossbar.sv */
/*
 * Full 32-way crossbar from the captured samples to the output register.
 * out_frame_o holds steady while out_valid_o is high and out_ready_i is low.
 */
`timescale 1ns/1ps

module fft_ord_crossbar (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            cap_valid_i,
    input  fft_frame_pkg::cplx_t [fft_cfg_pkg::FFT_LEN-1:0] cap_samples_i,
    input  fft_frame_pkg::idx_list_t                        idx_list_i,
    input  fft_cfg_pkg::stage_t                             stage_i,
    output logic                                            cap_ready_o,
    output logic                                            out_valid_o,
    output fft_frame_pkg::frame_t                           out_frame_o,
    input  logic                                            out_ready_i
);

    logic                                             xbar_load;
    fft_frame_pkg::cplx_t [fft_cfg_pkg::FFT_LEN-1:0]  sel_samples;

    // --------------------
    // handshake
    // --------------------

    // output register is free, or is emptied on this edge
    assign cap_ready_o = !out_valid_o || out_ready_i;
    assign xbar_load   = cap_valid_i && cap_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (xbar_load) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // --------------------
    // sample select
    // --------------------

    // re and im follow the same index, each is its own 32:1 mux
    always_comb begin
        for (int i = 0; i < fft_cfg_pkg::FFT_LEN; i++) begin
            sel_samples[i].re = cap_samples_i[idx_list_i[i]].re;
            sel_samples[i].im = cap_samples_i[idx_list_i[i]].im;
        end
    end

    // stage goes out untouched next to the reordered samples
    always_ff @(posedge clk) begin
        if (xbar_load) begin
            out_frame_o.stage   <= stage_i;
            out_frame_o.samples <= sel_samples;
        end
    end

endmodule

/* src/fft_ord_top.sv */
/*
 * Reorder unit top, two register slots deep.
 * One frame per cycle with no back-pressure.
 * A stall reaches in_ready_o once both slots hold a frame.
 */
`timescale 1ns/1ps

module fft_ord_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   in_valid_i,
    input  fft_frame_pkg::frame_t  in_frame_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    output fft_frame_pkg::frame_t  out_frame_o,
    input  logic                   out_ready_i
);

    logic                                             cap_load;
    logic                                             cap_valid;
    logic                                             cap_ready;
    fft_frame_pkg::cplx_t [fft_cfg_pkg::FFT_LEN-1:0]  cap_samples;
    fft_frame_pkg::idx_list_t                         idx_list;
    fft_cfg_pkg::stage_t                              idx_stage;

    // --------------------
    // first slot
    // --------------------

    fft_ord_capture u_capture (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_frame_i    (in_frame_i),
        .in_ready_o    (in_ready_o),
        .load_o        (cap_load),
        .cap_valid_o   (cap_valid),
        .cap_samples_o (cap_samples),
        .cap_ready_i   (cap_ready)
    );

    // list lines up with cap_samples because both load on cap_load
    fft_ord_index_table u_index_table (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .load_i     (cap_load),
        .stage_i    (in_frame_i.stage),
        .idx_list_o (idx_list),
        .stage_o    (idx_stage)
    );

    // --------------------
    // output slot
    // --------------------

    fft_ord_crossbar u_crossbar (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cap_valid_i   (cap_valid),
        .cap_samples_i (cap_samples),
        .idx_list_i    (idx_list),
        .stage_i       (idx_stage),
        .cap_ready_o   (cap_ready),
        .out_valid_o   (out_valid_o),
        .out_frame_o   (out_frame_o),
        .out_ready_i   (out_ready_i)
    );

endmodule

/* sim/fft_ord_assertions.sv */
/*
 * Output handshake and reset rules of the reorder unit, bound into fft_ord_top.
 * cap_valid is taken from inside the top level.
 */
`timescale 1ns/1ps

module fft_ord_assertions (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  cap_valid_i,
    input logic                  out_valid_i,
    input logic                  out_ready_i,
    input fft_frame_pkg::frame_t out_frame_i
);

    // a stalled frame keeps both its valid and its data
    stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_frame_i)))
        else $error("out_frame_o changed while the output was stalled");

    reset_out_valid_a: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
        else $error("out_valid_o high during reset");

    reset_cap_valid_a: assert property (@(posedge clk_i) !rst_n_i |=> !cap_valid_i)
        else $error("cap_valid high during reset");

endmodule

bind fft_ord_top fft_ord_assertions u_assertions (
    .clk_i       (clk),
    .rst_n_i     (rst_n_i),
    .cap_valid_i (cap_valid),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_frame_i (out_frame_o)
);

/* sim/tb_clk_gen.sv */
/*
 * Free running 100 ns clock, reset held low over the first 5 rising edges.
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #50;
            clk_o = ~clk_o;
        end
    end

    // released 1 ns after the fifth edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* sim/tb_fft_ord_checker.sv */
/*
 * Scoreboard of the reorder unit. Both handshakes are sampled at the falling edge.
 * Sample 0 of an accepted frame gives the re and im bases of that frame.
 */
`timescale 1ns/1ps

module tb_fft_ord_checker (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  in_valid_i,
    input  logic                  in_ready_i,
    input  fft_frame_pkg::frame_t in_frame_i,
    input  fft_cfg_pkg::index_t   exp_src1_i,
    input  fft_cfg_pkg::index_t   exp_src31_i,
    input  logic                  out_valid_i,
    input  logic                  out_ready_i,
    input  fft_frame_pkg::frame_t out_frame_i,
    output int                    pass_cnt_o,
    output int                    fail_cnt_o,
    output int                    out_cnt_o
);

    typedef struct packed {
        fft_cfg_pkg::stage_t  stage;
        fft_cfg_pkg::sample_t re_base;
        fft_cfg_pkg::sample_t im_base;
        fft_cfg_pkg::index_t  src1;
        fft_cfg_pkg::index_t  src31;
    } exp_rec_t;

    exp_rec_t pending[$];
    logic     seen_input;

    // source of output position pos by the reorder rule
    function automatic int src_index(input int stage, input int pos);
        int low;
        int src;
        src = pos;
        if (stage == 0) begin
            src = 0;
            for (int b = 0; b < 5; b++) begin
                if (((pos >> b) & 1) == 1) begin
                    src = src + (16 >> b);
                end
            end
        end else if (stage <= 4) begin
            // the lsb of the low stage+1 bits moves to the top of that window
            low = pos % (2 << stage);
            src = pos - low + (low / 2) + (low % 2) * (1 << stage);
        end
        return src;
    endfunction

    task automatic record_input();
        exp_rec_t rec;
        rec.stage   = in_frame_i.stage;
        rec.re_base = in_frame_i.samples[0].re;
        rec.im_base = in_frame_i.samples[0].im;
        rec.src1    = exp_src1_i;
        rec.src31   = exp_src31_i;
        pending.push_back(rec);
        seen_input = 1'b1;
    endtask

    task automatic check_output();
        exp_rec_t             rec;
        int                   src;
        int                   errs;
        fft_cfg_pkg::sample_t exp_re;
        fft_cfg_pkg::sample_t exp_im;
        errs = 0;
        if (pending.size() == 0) begin
            $display("time %0t: a frame came out with no frame pending", $time);
            fail_cnt_o++;
            return;
        end
        rec = pending.pop_front();
        if (out_frame_i.stage !== rec.stage) begin
            $display("ERR t=%0t out_frame_o.stage exp=%0d got=%0d",
                     $time, rec.stage, out_frame_i.stage);
            errs++;
        end
        for (int p = 0; p < fft_cfg_pkg::FFT_LEN; p++) begin
            src    = src_index(int'(rec.stage), p);
            exp_re = fft_cfg_pkg::sample_t'(int'(rec.re_base) + src);
            exp_im = fft_cfg_pkg::sample_t'(int'(rec.im_base) - src);
            if (out_frame_i.samples[p].re !== exp_re) begin
                $display("ERR t=%0t out_frame_o.samples[%0d].re exp=%h got=%h",
                         $time, p, exp_re, out_frame_i.samples[p].re);
                errs++;
            end
            if (out_frame_i.samples[p].im !== exp_im) begin
                $display("ERR t=%0t out_frame_o.samples[%0d].im exp=%h got=%h",
                         $time, p, exp_im, out_frame_i.samples[p].im);
                errs++;
            end
        end
        // outputs 1 and 31 against the source columns of the stimulus file
        exp_re = fft_cfg_pkg::sample_t'(int'(rec.re_base) + int'(rec.src1));
        if (out_frame_i.samples[1].re !== exp_re) begin
            $display("ERR t=%0t out_frame_o.samples[1].re exp=%h got=%h",
                     $time, exp_re, out_frame_i.samples[1].re);
            errs++;
        end
        exp_re = fft_cfg_pkg::sample_t'(int'(rec.re_base) + int'(rec.src31));
        if (out_frame_i.samples[31].re !== exp_re) begin
            $display("ERR t=%0t out_frame_o.samples[31].re exp=%h got=%h",
                     $time, exp_re, out_frame_i.samples[31].re);
            errs++;
        end
        if (errs == 0) begin
            $display("frame %0d stage %0d: ok", out_cnt_o, rec.stage);
            pass_cnt_o++;
        end else begin
            $display("frame %0d stage %0d: failed, %0d mismatches", out_cnt_o, rec.stage, errs);
            fail_cnt_o++;
        end
        out_cnt_o++;
    endtask

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            pass_cnt_o = 0;
            fail_cnt_o = 0;
            out_cnt_o  = 0;
            seen_input = 1'b0;
            pending.delete();
        end else begin
            if (!seen_input && out_valid_i) begin
                $display("time %0t: out_valid_o high before any frame was accepted", $time);
                fail_cnt_o++;
            end
            if (!seen_input && !in_ready_i) begin
                $display("time %0t: in_ready_o low while the unit is empty", $time);
                fail_cnt_o++;
            end
            if (out_valid_i && out_ready_i) begin
                check_output();
            end
            if (in_valid_i && in_ready_i) begin
                record_input();
            end
        end
    end

endmodule

/* sim/tb_fft_ord.sv */
/*
 * Testbench top of the reorder unit, to be run from the project root.
 * The first BURST_FRAMES frames go back to back, later ones see random gaps and stalls.
 */
`timescale 1ns/1ps

module tb_fft_ord;

    localparam int          MAX_FRAMES   = 64;
    localparam int          REC_WORDS    = 5;
    localparam int          BURST_FRAMES = 10;
    localparam logic [31:0] LCG_SEED     = 32'h9593_4b44;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    fft_frame_pkg::frame_t in_frame;
    logic                  in_ready;
    logic                  out_valid;
    fft_frame_pkg::frame_t out_frame;
    logic                  out_ready;
    fft_cfg_pkg::index_t   exp_src1;
    fft_cfg_pkg::index_t   exp_src31;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    out_cnt;

    logic [31:0] stim_mem [0:MAX_FRAMES*REC_WORDS-1];
    logic [31:0] lcg_state;
    int          n_frames;
    int          sent;
    int          cycles;
    int          cycle_limit;
    logic        accepted;
    logic        timed_out;
    logic        done;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fft_ord_top dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .in_valid_i  (in_valid),
        .in_frame_i  (in_frame),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_frame_o (out_frame),
        .out_ready_i (out_ready)
    );

    tb_fft_ord_checker u_checker (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_valid_i  (in_valid),
        .in_ready_i  (in_ready),
        .in_frame_i  (in_frame),
        .exp_src1_i  (exp_src1),
        .exp_src31_i (exp_src31),
        .out_valid_i (out_valid),
        .out_ready_i (out_ready),
        .out_frame_i (out_frame),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt),
        .out_cnt_o   (out_cnt)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------
    // stimulus
    // --------------------

    // unused words stay all ones, which ends the frame count
    task automatic load_stimulus();
        for (int w = 0; w < MAX_FRAMES * REC_WORDS; w++) begin
            stim_mem[w] = '1;
        end
        $readmemh("sim/fft_ord_stimulus.txt", stim_mem);
        n_frames = 0;
        while (n_frames < MAX_FRAMES && stim_mem[n_frames * REC_WORDS] != '1) begin
            n_frames++;
        end
    endtask

    task automatic present_frame(input int f);
        logic [31:0] re_base;
        logic [31:0] im_base;
        re_base        = stim_mem[f * REC_WORDS + 1];
        im_base        = stim_mem[f * REC_WORDS + 2];
        in_frame.stage = fft_cfg_pkg::stage_t'(stim_mem[f * REC_WORDS]);
        for (int k = 0; k < fft_cfg_pkg::FFT_LEN; k++) begin
            in_frame.samples[k].re = fft_cfg_pkg::sample_t'(re_base + k);
            in_frame.samples[k].im = fft_cfg_pkg::sample_t'(im_base - k);
        end
        exp_src1  = fft_cfg_pkg::index_t'(stim_mem[f * REC_WORDS + 3]);
        exp_src31 = fft_cfg_pkg::index_t'(stim_mem[f * REC_WORDS + 4]);
        in_valid  = 1'b1;
    endtask

    // called 1 ns after a rising edge, acceptance was sampled at the falling edge before
    task automatic drive_cycle();
        if (accepted) begin
            in_valid = 1'b0;
            accepted = 1'b0;
            sent++;
        end
        lcg_state = lcg_step(lcg_state);
        out_ready = (sent < BURST_FRAMES) ? 1'b1 : (lcg_state[31:28] > 4'd4);
        if (!in_valid && sent < n_frames) begin
            lcg_state = lcg_step(lcg_state);
            if (sent < BURST_FRAMES || lcg_state[31:28] > 4'd3) begin
                present_frame(sent);
            end
        end
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        in_valid  = 1'b0;
        in_frame  = '0;
        out_ready = 1'b0;
        exp_src1  = '0;
        exp_src31 = '0;
        lcg_state = LCG_SEED;
        sent      = 0;
        cycles    = 0;
        accepted  = 1'b0;
        timed_out = 1'b0;
        done      = 1'b0;
        load_stimulus();
        cycle_limit = 20 * n_frames + 50;
        @(posedge rst_n);
        while (!done) begin
            @(posedge clk);
            #1;
            if (out_cnt == n_frames) begin
                done = 1'b1;
            end else if (cycles >= cycle_limit) begin
                timed_out = 1'b1;
                done      = 1'b1;
            end else begin
                drive_cycle();
                @(negedge clk);
                accepted = in_valid && in_ready;
                cycles++;
            end
        end
        // a few idle cycles catch frames that come out twice
        if (!timed_out) begin
            in_valid  = 1'b0;
            out_ready = 1'b1;
            repeat (5) @(posedge clk);
            #1;
        end
        if (timed_out) begin
            $display("timeout: %0d of %0d frames came out within %0d cycles",
                     out_cnt, n_frames, cycle_limit);
        end
        if (n_frames == 0) begin
            $display("the stimulus file holds no frames");
        end
        $display("summary: %0d of %0d frames out, %0d passed, %0d failed",
                 out_cnt, n_frames, pass_cnt, fail_cnt);
        if (!timed_out && n_frames > 0 && fail_cnt == 0 && out_cnt == n_frames) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/fft_ord_stimulus.txt */
// one frame per line, hex: stage re_base im_base src_of_out1 src_of_out31
// sample k of a frame has re = re_base + k and im = im_base - k
0 0100 7f00 10 1f
5 0200 6e00 01 1f
1 0300 5d00 02 1f
6 0400 4c00 01 1f
2 0500 3b00 04 1f
7 0600 2a00 01 1f
3 0700 1900 08 1f
0 0800 0800 10 1f
4 0900 f700 10 1f
5 0a00 e600 01 1f
1 8000 0005 02 1f
3 7ff0 8010 08 1f
0 ffe0 0000 10 1f
7 1234 4321 01 1f
4 c000 3fff 10 1f
2 0001 ffff 04 1f
6 5555 aaaa 01 1f
1 2468 1357 02 1f
3 0f0f f0f0 08 1f
4 7fff 8000 10 1f

/* tb.f */
src/fft_cfg_pkg.sv
src/fft_frame_pkg.sv
src/fft_ord_capture.sv
src/fft_ord_index_table.sv
src/fft_ord_crossbar.sv
src/fft_ord_top.sv
sim/fft_ord_assertions.sv
sim/tb_clk_gen.sv
sim/tb_fft_ord_checker.sv
sim/tb_fft_ord.sv

/* run_sim.sh */
#!/bin/sh
# builds the reorder unit testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fft_ord -f tb.f -o tb_fft_ord
./obj_dir/tb_fft_ord | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail, see sim.log"
exit 1
